// File: verilog/cachePkg.sv
`default_nettype none

package cachePkg;

    localparam int ADDR_W   = 32;  // CPU byte address
    localparam int WORD_W   = 32;  // CPU data word
    localparam int BLOCK_W  = 128; // One cache line
    localparam int OFFSET_W = 4;   // Byte offset inside a line

    typedef logic [BLOCK_W-1:0] blockT;

    // RISC-V func3 codes, bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        opLb  = 3'b000,
        opLh  = 3'b001,
        opLw  = 3'b010,
        opLbu = 3'b100,
        opLhu = 3'b101
    } memOpE;

    // Stores reuse the func3 codes of the loads
    // The write bit of the request tells them apart
    localparam memOpE opSb = opLb;
    localparam memOpE opSh = opLh;
    localparam memOpE opSw = opLw;

    typedef struct packed {
        logic              valid; // Request present this cycle
        logic              write; // Store when set, load otherwise
        memOpE             op;    // Access size and extension
        logic [ADDR_W-1:0] addr;  // Byte address, naturally aligned
        logic [WORD_W-1:0] wdata; // Store data, low aligned
    } cpuReqT;

    typedef struct packed {
        logic              ready; // Low while the cache stalls
        logic [WORD_W-1:0] rdata; // Extended load result
    } cpuRspT;

    typedef struct packed {
        logic                  en;       // Write strobe
        logic [ADDR_W-3:0]     wordAddr; // Word index
        logic [WORD_W/8-1:0]   byteEn;   // One bit per byte lane
        logic [WORD_W-1:0]     data;     // Lane-placed store data
    } wordWriteT;

    // Refill sequencer
    typedef enum logic [1:0] {
        stIdle,      // Lookup, hits and stores
        stFillWait,  // Block read in flight
        stFillWrite  // Line filled, lookup again
    } ctrlStateE;

endpackage

`default_nettype wire

// File: verilog/loadStoreAlign.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreAlign (
    input  cachePkg::memOpE                    op,
    input  logic [cachePkg::OFFSET_W-1:0]      offset,     // Byte offset in the line
    input  cachePkg::blockT                    lineIn,     // Line from the hit way
    input  logic [cachePkg::WORD_W-1:0]        wdata,
    output logic [cachePkg::WORD_W-1:0]        rdata,
    output logic [cachePkg::BLOCK_W/8-1:0]     lineByteEn,
    output cachePkg::blockT                    lineData,
    output logic [cachePkg::WORD_W/8-1:0]      wordByteEn,
    output logic [cachePkg::WORD_W-1:0]        wordData
);

    localparam int laneN = cachePkg::BLOCK_W / 8;
    localparam int wLane = cachePkg::WORD_W / 8;
    localparam int reps  = cachePkg::BLOCK_W / cachePkg::WORD_W;

    logic [cachePkg::WORD_W-1:0] word;    // Addressed word of the line
    logic [7:0]                  byteSel;
    logic [15:0]                 halfSel;

    assign word    = lineIn[offset[cachePkg::OFFSET_W-1:2]*cachePkg::WORD_W +: cachePkg::WORD_W];
    assign byteSel = word[offset[1:0]*8 +: 8];
    assign halfSel = word[offset[1]*16 +: 16]; // Aligned halves only

    always_comb begin
        case (op)
            cachePkg::opLb:  rdata = {{24{byteSel[7]}}, byteSel};
            cachePkg::opLh:  rdata = {{16{halfSel[15]}}, halfSel};
            cachePkg::opLbu: rdata = {24'h0, byteSel};
            cachePkg::opLhu: rdata = {16'h0, halfSel};
            default:         rdata = word; // opLw
        endcase
    end

    // Store data copied to every lane, byte enables pick the target
    always_comb begin
        wordByteEn = '0;
        wordData   = wdata;
        case (op)
            cachePkg::opSb: begin
                wordByteEn = wLane'(1) << offset[1:0];
                wordData   = {4{wdata[7:0]}};
            end
            cachePkg::opSh: begin
                wordByteEn = wLane'(3) << {offset[1], 1'b0};
                wordData   = {2{wdata[15:0]}};
            end
            cachePkg::opSw: wordByteEn = '1;
            default:        wordByteEn = '0; // Not a store size
        endcase
    end

    assign lineByteEn = laneN'(wordByteEn) << (offset[cachePkg::OFFSET_W-1:2] * wLane);
    assign lineData   = {reps{wordData}}; // Same word in every slot

endmodule

`default_nettype wire

// File: verilog/cacheWayStore.sv
`timescale 1ns/100ps
`default_nettype none

module cacheWayStore #(
    parameter int ways   = 4,
    parameter int setNum = 64
) (
    input  logic                                      clk,
    input  logic                                      arstN,
    input  logic [$clog2(setNum)-1:0]                 index,
    input  logic [cachePkg::ADDR_W-cachePkg::OFFSET_W-$clog2(setNum)-1:0] tag,
    input  logic                                      fillEn,      // Replace victim line
    input  cachePkg::blockT                           fillData,
    input  logic                                      storeEn,     // Merge into hit line
    input  logic [cachePkg::BLOCK_W/8-1:0]            storeByteEn,
    input  cachePkg::blockT                           storeData,
    input  logic                                      touch,       // Hit access, LRU update
    output logic                                      hit,
    output cachePkg::blockT                           hitBlock
);

    localparam int tagW  = cachePkg::ADDR_W - cachePkg::OFFSET_W - $clog2(setNum);
    localparam int wayW  = $clog2(ways);         // Also the LRU age width
    localparam int laneN = cachePkg::BLOCK_W / 8;

    logic [ways-1:0]     validQ  [setNum];       // Cleared by reset
    logic [wayW-1:0]     ageQ    [setNum][ways]; // 0 is most recent
    logic [tagW-1:0]     tagMem  [setNum][ways];
    cachePkg::blockT     dataMem [setNum][ways];

    logic [wayW-1:0]     hitWay;
    logic [wayW-1:0]     victim;
    logic [wayW-1:0]     accessWay;              // Way whose age drops to 0

    always_comb begin
        hit    = 1'b0;
        hitWay = '0;
        for (int w = 0; w < ways; w++) begin
            if (validQ[index][w] && (tagMem[index][w] == tag)) begin
                hit    = 1'b1;
                hitWay = wayW'(w);
            end
        end
    end

    assign hitBlock = dataMem[index][hitWay];

    // Oldest way, overridden by the lowest invalid way
    always_comb begin
        victim = '0;
        for (int w = 0; w < ways; w++) begin
            if (ageQ[index][w] == wayW'(ways - 1)) victim = wayW'(w);
        end
        for (int w = ways - 1; w >= 0; w--) begin
            if (!validQ[index][w]) victim = wayW'(w);
        end
    end

    assign accessWay = fillEn ? victim : hitWay;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int s = 0; s < setNum; s++) begin
                validQ[s] <= '0;
                for (int w = 0; w < ways; w++) begin
                    ageQ[s][w] <= wayW'(w); // Distinct ages, a valid LRU order
                end
            end
        end else begin
            if (fillEn) validQ[index][victim] <= 1'b1;
            if (fillEn || touch) begin
                for (int w = 0; w < ways; w++) begin
                    if (wayW'(w) == accessWay) begin
                        ageQ[index][w] <= '0;
                    end else if (ageQ[index][w] < ageQ[index][accessWay]) begin
                        ageQ[index][w] <= ageQ[index][w] + 1'b1; // Younger ways age
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fillEn) begin
            tagMem[index][victim]  <= tag;
            dataMem[index][victim] <= fillData;
        end else if (storeEn && hit) begin
            for (int b = 0; b < laneN; b++) begin
                if (storeByteEn[b]) dataMem[index][hitWay][8*b +: 8] <= storeData[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/blockRam.sv
`timescale 1ns/100ps
`default_nettype none

module blockRam #(
    parameter int ramAddrW   = 18,
    parameter int ramLatency = 4
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  cachePkg::wordWriteT           wordWrite,  // Byte-enabled store
    input  logic                          blockRead,  // Start a block fetch
    input  logic [cachePkg::ADDR_W-1:0]   blockAddr,  // Block aligned
    output logic                          blockReady, // ramLatency cycles after blockRead
    output cachePkg::blockT               blockData
);

    localparam int wordIdxW    = ramAddrW - 2;
    localparam int blkIdxW     = ramAddrW - cachePkg::OFFSET_W;
    localparam int selW        = cachePkg::OFFSET_W - 2;       // Word select in a block
    localparam int wordsPerBlk = cachePkg::BLOCK_W / cachePkg::WORD_W;
    localparam int wLane       = cachePkg::WORD_W / 8;

    logic [cachePkg::WORD_W-1:0] mem [2**wordIdxW];
    logic [ramLatency-1:0]       readValid;             // Fetch in flight per stage
    logic [blkIdxW-1:0]          readBlk [ramLatency];  // Block index per stage
    logic [wordIdxW-1:0]         wrIdx;

    // Each byte holds its own low address bits XOR 8'h5A
    initial begin
        for (int w = 0; w < 2**wordIdxW; w++) begin
            for (int b = 0; b < wLane; b++) begin
                mem[w][8*b +: 8] = 8'(w * wLane + b) ^ 8'h5A;
            end
        end
    end

    assign wrIdx = wordWrite.wordAddr[wordIdxW-1:0];

    always @(posedge clk) begin
        if (wordWrite.en) begin
            for (int b = 0; b < wLane; b++) begin
                if (wordWrite.byteEn[b]) mem[wrIdx][8*b +: 8] <= wordWrite.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readValid <= '0;
        end else begin
            readValid[0] <= blockRead;
            for (int i = 1; i < ramLatency; i++) begin
                readValid[i] <= readValid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        readBlk[0] <= blockAddr[ramAddrW-1:cachePkg::OFFSET_W];
        for (int i = 1; i < ramLatency; i++) begin
            readBlk[i] <= readBlk[i-1];
        end
    end

    assign blockReady = readValid[ramLatency-1];

    // Array read at the last stage
    always_comb begin
        for (int k = 0; k < wordsPerBlk; k++) begin
            blockData[k*cachePkg::WORD_W +: cachePkg::WORD_W] =
                mem[{readBlk[ramLatency-1], selW'(k)}];
        end
    end

endmodule

`default_nettype wire

// File: verilog/l1Cache.sv
`timescale 1ns/100ps
`default_nettype none

module l1Cache #(
    parameter int ways   = 4,
    parameter int setNum = 64
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  cachePkg::cpuReqT              cpuReq,
    output cachePkg::cpuRspT              cpuRsp,
    output logic                          blockRead,  // One cycle fetch request
    output logic [cachePkg::ADDR_W-1:0]   blockAddr,
    input  logic                          blockReady, // Fetch data valid
    input  cachePkg::blockT               blockData,
    output cachePkg::wordWriteT           wordWrite,  // Store path to RAM
    output logic                          cacheHit,
    output logic                          cacheMiss
);

    localparam int idxW  = $clog2(setNum);
    localparam int tagW  = cachePkg::ADDR_W - cachePkg::OFFSET_W - idxW;
    localparam int laneN = cachePkg::BLOCK_W / 8;      // Byte lanes per line
    localparam int wLane = cachePkg::WORD_W / 8;       // Byte lanes per word

    cachePkg::ctrlStateE state;
    cachePkg::ctrlStateE nextState;

    logic [idxW-1:0]               index;
    logic [tagW-1:0]               tag;
    logic [cachePkg::OFFSET_W-1:0] offset;

    logic                          hit;        // Tag match in the indexed set
    cachePkg::blockT               hitBlock;   // Line of the matching way
    logic                          loadReq;
    logic                          storeReq;
    logic                          missNow;    // Load that cannot complete now
    logic                          ready;
    logic                          fillEn;     // Write fetched line
    logic                          storeEn;    // Merge store into cached line
    logic                          touch;      // LRU update on access
    logic [cachePkg::WORD_W-1:0]   loadData;
    logic [laneN-1:0]              lineByteEn;
    cachePkg::blockT               lineData;
    logic [wLane-1:0]              wordByteEn;
    logic [cachePkg::WORD_W-1:0]   wordData;

    // Address split: tag | index | offset
    assign offset = cpuReq.addr[cachePkg::OFFSET_W-1:0];
    assign index  = cpuReq.addr[cachePkg::OFFSET_W +: idxW];
    assign tag    = cpuReq.addr[cachePkg::ADDR_W-1 -: tagW];

    assign loadReq  = cpuReq.valid && !cpuReq.write;
    assign storeReq = cpuReq.valid && cpuReq.write;
    assign missNow  = loadReq && !hit;

    // No completion while the fetch is outstanding
    assign ready = (state != cachePkg::stFillWait) && !missNow;

    assign cacheHit  = (state == cachePkg::stIdle) && loadReq && hit; // First lookup only
    assign cacheMiss = (state == cachePkg::stIdle) && missNow;
    assign blockRead = cacheMiss;                                      // Issue with the miss
    assign blockAddr = {cpuReq.addr[cachePkg::ADDR_W-1:cachePkg::OFFSET_W],
                        {cachePkg::OFFSET_W{1'b0}}};

    assign fillEn  = (state == cachePkg::stFillWait) && blockReady;
    assign storeEn = storeReq && ready && hit;   // Write-through, no allocate
    assign touch   = cpuReq.valid && ready && hit; // Loads and store hits

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cachePkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cachePkg::stIdle: begin
                if (missNow) nextState = cachePkg::stFillWait; // Fetch issued
            end
            cachePkg::stFillWait: begin
                if (blockReady) nextState = cachePkg::stFillWrite;
            end
            cachePkg::stFillWrite: nextState = cachePkg::stIdle; // Relookup hits here
            default: nextState = cachePkg::stIdle;
        endcase
    end

    always_comb begin
        cpuRsp.ready = ready;
        cpuRsp.rdata = loadData;
    end

    always_comb begin
        wordWrite.en       = storeReq && ready; // Every store reaches RAM
        wordWrite.wordAddr = cpuReq.addr[cachePkg::ADDR_W-1:2];
        wordWrite.byteEn   = wordByteEn;
        wordWrite.data     = wordData;
    end

    cacheWayStore #(
        .ways   (ways),
        .setNum (setNum)
    ) cacheWayStore_inst (
        .clk         (clk),
        .arstN       (arstN),
        .index       (index),
        .tag         (tag),
        .fillEn      (fillEn),
        .fillData    (blockData),
        .storeEn     (storeEn),
        .storeByteEn (lineByteEn),
        .storeData   (lineData),
        .touch       (touch),
        .hit         (hit),
        .hitBlock    (hitBlock)
    );

    loadStoreAlign loadStoreAlign_inst (
        .op         (cpuReq.op),
        .offset     (offset),
        .lineIn     (hitBlock),
        .wdata      (cpuReq.wdata),
        .rdata      (loadData),
        .lineByteEn (lineByteEn),
        .lineData   (lineData),
        .wordByteEn (wordByteEn),
        .wordData   (wordData)
    );

endmodule

`default_nettype wire

// File: verilog/cacheMemoryTop.sv
`timescale 1ns/100ps
`default_nettype none

module cacheMemoryTop #(
    parameter int ways       = 4,  // Associativity
    parameter int setNum     = 64, // Sets in the cache
    parameter int ramAddrW   = 18, // RAM byte address bits
    parameter int ramLatency = 4   // Block read delay in cycles
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  cachePkg::cpuReqT              cpuReq,    // Held while stall is high
    output logic [cachePkg::WORD_W-1:0]   rdata,     // Load result
    output logic                          stall,     // CPU back-pressure
    output logic                          cacheHit,  // Load hit on first lookup
    output logic                          cacheMiss  // Load miss, fetch issued
);

    cachePkg::cpuRspT              cpuRsp;     // Ready and load data
    logic                          blockRead;  // Fetch pulse to RAM
    logic [cachePkg::ADDR_W-1:0]   blockAddr;  // Block aligned fetch address
    logic                          blockReady; // Fetch data valid pulse
    cachePkg::blockT               blockData;  // Fetched line
    cachePkg::wordWriteT           wordWrite;  // Write-through store

    l1Cache #(
        .ways   (ways),
        .setNum (setNum)
    ) l1Cache_inst (
        .clk        (clk),
        .arstN      (arstN),
        .cpuReq     (cpuReq),
        .cpuRsp     (cpuRsp),
        .blockRead  (blockRead),
        .blockAddr  (blockAddr),
        .blockReady (blockReady),
        .blockData  (blockData),
        .wordWrite  (wordWrite),
        .cacheHit   (cacheHit),
        .cacheMiss  (cacheMiss)
    );

    blockRam #(
        .ramAddrW   (ramAddrW),
        .ramLatency (ramLatency)
    ) blockRam_inst (
        .clk        (clk),
        .arstN      (arstN),
        .wordWrite  (wordWrite),
        .blockRead  (blockRead),
        .blockAddr  (blockAddr),
        .blockReady (blockReady),
        .blockData  (blockData)
    );

    assign rdata = cpuRsp.rdata;  // Valid when stall is low
    assign stall = !cpuRsp.ready; // Miss or refill in progress

endmodule

`default_nettype wire

// File: verification/cacheMemoryTb.sv
`timescale 1ns/100ps
`default_nettype none

module cacheMemoryTb;

    localparam int ramAddrW   = 18;
    localparam int ramLatency = 4;
    localparam int maxEntries = 64;
    localparam int randCount  = 24;         // Extra entries after the directed ones
    localparam int setNum     = 64;
    localparam int ways       = 4;

    logic                        clk;
    logic                        arstN;
    cachePkg::cpuReqT            cpuReq;
    logic [cachePkg::WORD_W-1:0] rdata;
    logic                        stall;
    logic                        cacheHit;
    logic                        cacheMiss;

    cachePkg::memOpE             opTab      [maxEntries];
    logic                        storeTab   [maxEntries];
    logic [cachePkg::ADDR_W-1:0] addrTab    [maxEntries];
    logic [cachePkg::WORD_W-1:0] wdataTab   [maxEntries];
    logic [cachePkg::WORD_W-1:0] expDataTab [maxEntries];
    logic                        expHitTab  [maxEntries];
    int                          numEntries = 0;
    int                          curEntry   = -1;

    logic [7:0]  ramModel [2**ramAddrW];    // Byte image of the RAM
    logic [27:0] lruBlk   [setNum][ways];   // Block numbers, most recent first
    int          lruCnt   [setNum];
    int          cycleCount = 0;
    int          cycleLimit = 0;             // Zero until the table is built
    integer      seed       = 32'h8832;

    cacheMemoryTop #(
        .ways       (ways),
        .setNum     (setNum),
        .ramAddrW   (ramAddrW),
        .ramLatency (ramLatency)
    ) cacheMemoryTop_inst (
        .clk       (clk),
        .arstN     (arstN),
        .cpuReq    (cpuReq),
        .rdata     (rdata),
        .stall     (stall),
        .cacheHit  (cacheHit),
        .cacheMiss (cacheMiss)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "Stopping after first error");
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit)
            stopOnError($sformatf("Timeout: run did not finish within %0d cycles", cycleLimit));
    end

    task automatic checkWord(input string name, input logic [cachePkg::WORD_W-1:0] got,
                             input logic [cachePkg::WORD_W-1:0] exp);
        if (got !== exp)
            stopOnError($sformatf("FAIL %s got 0x%h expected 0x%h (entry %0d)",
                                  name, got, exp, curEntry));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stopOnError($sformatf("FAIL %s got 0x%h expected 0x%h (entry %0d)",
                                  name, got, exp, curEntry));
    endtask

    // Little endian bytes with func3 extension
    function automatic logic [31:0] loadExpect(input cachePkg::memOpE op,
                                               input logic [31:0] addr);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = ramModel[addr];
        b1 = ramModel[addr + 1];
        b2 = ramModel[addr + 2];
        b3 = ramModel[addr + 3];
        case (op)
            cachePkg::opLb:  return {{24{b0[7]}}, b0};
            cachePkg::opLh:  return {{16{b1[7]}}, b1, b0};
            cachePkg::opLbu: return {24'h0, b0};
            cachePkg::opLhu: return {16'h0, b1, b0};
            default:         return {b3, b2, b1, b0};
        endcase
    endfunction

    // True LRU per set where stores touch on hit and never allocate
    task automatic cacheModelAccess(input logic isStore, input logic [31:0] addr,
                                    output logic hit);
        logic [27:0] blk;
        int          set;
        int          found;
        int          pos;
        blk   = addr[31:4];
        set   = int'(blk[5:0]);
        found = -1;
        for (int i = 0; i < lruCnt[set]; i++) begin
            if (lruBlk[set][i] == blk) found = i;
        end
        hit = (found >= 0);
        if (hit || !isStore) begin
            pos = hit ? found : ((lruCnt[set] == ways) ? ways - 1 : lruCnt[set]); // LRU slot drops
            if (!hit && lruCnt[set] < ways) lruCnt[set]++;
            for (int i = pos; i > 0; i--) lruBlk[set][i] = lruBlk[set][i-1];
            lruBlk[set][0] = blk;
        end
    endtask

    task automatic addLoad(input cachePkg::memOpE op, input logic [31:0] addr);
        logic hit;
        cacheModelAccess(1'b0, addr, hit);
        opTab[numEntries]      = op;
        storeTab[numEntries]   = 1'b0;
        addrTab[numEntries]    = addr;
        wdataTab[numEntries]   = '0;
        expDataTab[numEntries] = loadExpect(op, addr);
        expHitTab[numEntries]  = hit;
        numEntries++;
    endtask

    task automatic addStore(input cachePkg::memOpE op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        logic hit;
        int   size;
        cacheModelAccess(1'b1, addr, hit);
        size = (op == cachePkg::opSb) ? 1 : ((op == cachePkg::opSh) ? 2 : 4);
        for (int i = 0; i < size; i++) ramModel[addr + i] = wdata[8*i +: 8]; // Write-through
        opTab[numEntries]      = op;
        storeTab[numEntries]   = 1'b1;
        addrTab[numEntries]    = addr;
        wdataTab[numEntries]   = wdata;
        expDataTab[numEntries] = '0;
        expHitTab[numEntries]  = hit;
        numEntries++;
    endtask

    task automatic addRandom();
        int          r;
        logic [31:0] addr;
        logic [31:0] wdata;
        r     = $unsigned($random(seed)) % 8;
        addr  = $random(seed) & 32'h7FF;   // Within 2 KB
        wdata = $random(seed);
        case (r)
            0: addLoad(cachePkg::opLb, addr);
            1: addLoad(cachePkg::opLh, addr & ~32'h1);
            2: addLoad(cachePkg::opLw, addr & ~32'h3);
            3: addLoad(cachePkg::opLbu, addr);
            4: addLoad(cachePkg::opLhu, addr & ~32'h1);
            5: addStore(cachePkg::opSb, addr, wdata);
            6: addStore(cachePkg::opSh, addr & ~32'h1, wdata);
            default: addStore(cachePkg::opSw, addr & ~32'h3, wdata);
        endcase
    endtask

    task automatic buildTable();
        addLoad(cachePkg::opLw, 32'h100);                 // Cold miss
        addLoad(cachePkg::opLw, 32'h104);                 // Same block, hit
        addLoad(cachePkg::opLb, 32'hDA);                  // Byte 8'h80
        addLoad(cachePkg::opLbu, 32'hDA);
        addLoad(cachePkg::opLb, 32'hD0);
        addLoad(cachePkg::opLh, 32'hDC);                  // Half 16'h8786
        addLoad(cachePkg::opLhu, 32'hDC);
        addLoad(cachePkg::opLb, 32'h10);                  // Positive byte
        addLoad(cachePkg::opLh, 32'h12);
        addLoad(cachePkg::opLw, 32'hD4);
        addStore(cachePkg::opSb, 32'h104, 32'h000000A5);  // Store hits
        addStore(cachePkg::opSh, 32'h106, 32'h00001234);
        addStore(cachePkg::opSw, 32'h108, 32'hCAFEF00D);
        addLoad(cachePkg::opLw, 32'h104);
        addLoad(cachePkg::opLw, 32'h108);
        addLoad(cachePkg::opLbu, 32'h104);
        addLoad(cachePkg::opLh, 32'h106);
        addStore(cachePkg::opSw, 32'h2040, 32'h13579BDF); // Store misses
        addStore(cachePkg::opSh, 32'h2046, 32'h0000FEDC);
        addLoad(cachePkg::opLw, 32'h2040);
        addLoad(cachePkg::opLhu, 32'h2046);
        addLoad(cachePkg::opLw, 32'h3050);                // First of five blocks in set 5
        addStore(cachePkg::opSw, 32'h3050, 32'h2468ACE0); // Hit, must also reach RAM
        for (int i = 1; i < 5; i++) begin
            addLoad(cachePkg::opLw, 32'h3050 + i * 32'h400);
        end
        addLoad(cachePkg::opLw, 32'h3050);                // Evicted, stored word from RAM
        addLoad(cachePkg::opLw, 32'h3C50);                // Still resident
        for (int i = 0; i < randCount; i++) addRandom();
    endtask

    task automatic applyEntry(input int idx);
        logic sawHit;
        logic sawMiss;
        logic sawStall;
        curEntry = idx;
        @(posedge clk);
        #1;
        cpuReq.valid = 1'b1;
        cpuReq.write = storeTab[idx];
        cpuReq.op    = opTab[idx];
        cpuReq.addr  = addrTab[idx];
        cpuReq.wdata = wdataTab[idx];
        @(negedge clk);                            // First lookup
        sawHit   = cacheHit;
        sawMiss  = cacheMiss;
        sawStall = stall;
        while (stall) @(negedge clk);              // Refill in progress
        checkFlag("cacheHit", sawHit, !storeTab[idx] && expHitTab[idx]);
        checkFlag("cacheMiss", sawMiss, !storeTab[idx] && !expHitTab[idx]);
        checkFlag("stall", sawStall, !storeTab[idx] && !expHitTab[idx]);
        if (!storeTab[idx]) checkWord("rdata", rdata, expDataTab[idx]);
    endtask

    initial begin
        arstN  = 1'b0;
        cpuReq = '0;
        for (int a = 0; a < 2**ramAddrW; a++) ramModel[a] = 8'(a) ^ 8'h5A; // Initial pattern
        for (int s = 0; s < setNum; s++) lruCnt[s] = 0;
        buildTable();
        cycleLimit = numEntries * (ramLatency + 6) + 50;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        checkFlag("stall", stall, 1'b0);           // Idle after reset
        checkFlag("cacheHit", cacheHit, 1'b0);
        checkFlag("cacheMiss", cacheMiss, 1'b0);
        for (int i = 0; i < numEntries; i++) applyEntry(i);
        @(posedge clk);
        #1;
        cpuReq = '0;
        @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/cachePkg.sv
verilog/loadStoreAlign.sv
verilog/cacheWayStore.sv
verilog/blockRam.sv
verilog/l1Cache.sv
verilog/cacheMemoryTop.sv
verification/cacheMemoryTb.sv

// File: Bender.yml
package:
  name: cache_memory

sources:
  - verilog/cachePkg.sv
  - verilog/loadStoreAlign.sv
  - verilog/cacheWayStore.sv
  - verilog/blockRam.sv
  - verilog/l1Cache.sv
  - verilog/cacheMemoryTop.sv
  - target: test
    files:
      - verification/cacheMemoryTb.sv
